//--- build.f
design/fp_pkg.sv
design/fp_align_stage.sv
design/fp_shift_mul_stage.sv
design/fp_add_stage.sv
design/fp_normalize_stage.sv
design/fp_pipeline_top.sv
testbench/fp_pipeline_asserts.sv
testbench/fp_pipeline_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the FP pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module fp_pipeline_tb -f build.f -o fp_pipeline_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/fp_pipeline_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
else
	echo "Pass message not found in sim.log"
	exit 1
fi

//--- testbench/fp_pipeline_tb.sv
// Runs with LANES fixed at 4; outputs are checked at the falling edge four cycles after each drive
`timescale 1ns/10ps
`default_nettype none

module fp_pipeline_tb
	import fp_pkg::*;
	();

	localparam int clk_period = 20;
	// Items issued over all tests, sets the watchdog limit
	localparam int issued_items = 18;

	// One pipeline item with its expected lane results, lane 0 in the low word
	typedef struct packed
	{
		fp_op_t op;
		thread_idx_t thread;
		logic [3:0] mask;
		logic [127:0] operand1;
		logic [127:0] operand2;
		logic [127:0] expected;
		logic rb_en;
		thread_idx_t rb_thread;
	} item_t;

	logic clk;
	logic reset;
	logic rollback_en;
	thread_idx_t rollback_thread;
	logic in_valid;
	fp_op_t in_op;
	thread_idx_t in_thread;
	logic [3:0] in_mask;
	float32_t [3:0] in_operand1;
	float32_t [3:0] in_operand2;
	logic out_valid;
	thread_idx_t out_thread;
	logic [3:0] out_mask;
	float32_t [3:0] out_result;

	item_t batch[$];

	fp_pipeline_top #(.LANES(4)) dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	// Hard stop if the pipeline or a test loop stalls
	initial
	begin
		#((issued_items + 4 + 50) * clk_period);
		$display("Watchdog timeout: tests did not complete in the expected time");
		$display("Simulation FAILED");
		$fatal(1, "Watchdog timeout");
	end

	task automatic check_value(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "Output mismatch");
		end
	endtask

	function automatic thread_idx_t random_thread();
		return thread_idx_t'($urandom_range(3));
	endfunction

	// Queue an item, mask is random since lanes compute regardless
	task automatic add_item(input fp_op_t op, input thread_idx_t thread,
		input logic [127:0] operand1, input logic [127:0] operand2,
		input logic [127:0] expected, input logic rb_en, input thread_idx_t rb_thread);
		item_t item;

		item.op = op;
		item.thread = thread;
		item.mask = 4'($urandom_range(15));
		item.operand1 = operand1;
		item.operand2 = operand2;
		item.expected = expected;
		item.rb_en = rb_en;
		item.rb_thread = rb_thread;
		batch.push_back(item);
	endtask

	task automatic drive_item(input item_t item);
		in_valid = 1'b1;
		in_op = item.op;
		in_thread = item.thread;
		in_mask = item.mask;
		in_operand1 = item.operand1;
		in_operand2 = item.operand2;
		rollback_en = item.rb_en;
		rollback_thread = item.rb_thread;
	endtask

	task automatic drive_idle();
		in_valid = 1'b0;
		rollback_en = 1'b0;
	endtask

	task automatic check_output(input string test_name, input logic expect_valid,
		input item_t item);
		check_value(test_name, "out_valid", 32'(expect_valid), 32'(out_valid));
		if (expect_valid)
		begin
			check_value(test_name, "out_thread", 32'(item.thread), 32'(out_thread));
			check_value(test_name, "out_mask", 32'(item.mask), 32'(out_mask));
			for (int lane = 0; lane < 4; lane++)
				check_value(test_name, $sformatf("out_result lane %0d", lane),
					item.expected[lane * 32 +: 32], out_result[lane]);
		end
	endtask

	// Issue queued items back to back and check each one four cycles later
	task automatic run_batch(input string test_name);
		int total;
		logic expect_valid;
		item_t item;

		total = batch.size();
		for (int cycle = 0; cycle < total + 4; cycle++)
		begin
			@(negedge clk);
			expect_valid = 1'b0;
			if (cycle >= 4)
			begin
				item = batch[cycle - 4];
				// Matching rollback thread drops the item on entry
				expect_valid = !(item.rb_en && item.rb_thread == item.thread);
			end
			check_output(test_name, expect_valid, item);
			if (cycle < total)
				drive_item(batch[cycle]);
			else
				drive_idle();
		end
		batch.delete();
	endtask

	// Lane words listed as lane 3 down to lane 0
	task automatic exact_add_sub_test();
		add_item(FP_ADD, random_thread(),
			{32'hbf800000, 32'h3f800000, 32'h40100000, 32'h3fc00000},
			{32'h40400000, 32'hbf800000, 32'h3fc00000, 32'h40100000},
			{32'h40000000, 32'h00000000, 32'h40700000, 32'h40700000}, 1'b0, 2'd0);
		add_item(FP_SUB, random_thread(),
			{32'h3fc00000, 32'h3f800000, 32'h40a00000, 32'h40400000},
			{32'h40100000, 32'h3f800000, 32'h40400000, 32'h40a00000},
			{32'hbf400000, 32'h00000000, 32'h40000000, 32'hc0000000}, 1'b0, 2'd0);
		run_batch("exact_add_sub");
	endtask

	task automatic multiply_test();
		// Lane 2 is a signed zero product
		add_item(FP_MUL, random_thread(),
			{32'h3fc00000, 32'h80000000, 32'h3f000000, 32'h40400000},
			{32'h3fc00000, 32'h40a00000, 32'h3e800000, 32'hc0000000},
			{32'h40100000, 32'h80000000, 32'h3e000000, 32'hc0c00000}, 1'b0, 2'd0);
		run_batch("multiply");
	endtask

	task automatic truncation_test();
		// Shift clamp, guard bit dropped, borrow from sticky, low bit dropped
		add_item(FP_ADD, random_thread(),
			{32'h4b800000, 32'h3f800000, 32'h3f800000, 32'h3f800000},
			{32'h3f800000, 32'hb0800000, 32'h3f000001, 32'h30800000},
			{32'h4b800000, 32'h3f7fffff, 32'h3fc00000, 32'h3f800000}, 1'b0, 2'd0);
		run_batch("truncation");
	endtask

	task automatic specials_test();
		// NaN operand, inf minus inf, signed inf, add overflow
		add_item(FP_ADD, random_thread(),
			{32'h7f7fffff, 32'hff800000, 32'h7f800000, 32'h7f800001},
			{32'h7f7fffff, 32'h3f800000, 32'hff800000, 32'h3f800000},
			{32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7fc00000}, 1'b0, 2'd0);
		// Inf times zero, overflow, underflow, inf sign from product
		add_item(FP_MUL, random_thread(),
			{32'hff800000, 32'h00800000, 32'h7f7fffff, 32'h7f800000},
			{32'hc0000000, 32'h80800000, 32'h40000000, 32'h00000000},
			{32'h7f800000, 32'h80000000, 32'h7f800000, 32'h7fc00000}, 1'b0, 2'd0);
		run_batch("specials");
	endtask

	task automatic streaming_test();
		for (int i = 0; i < 8; i++)
		begin
			case (i % 4)
				0: add_item(FP_ADD, random_thread(), {4{32'h3fc00000}}, {4{32'h40100000}},
					{4{32'h40700000}}, 1'b0, 2'd0);
				1: add_item(FP_SUB, random_thread(), {4{32'h40400000}}, {4{32'h40a00000}},
					{4{32'hc0000000}}, 1'b0, 2'd0);
				2: add_item(FP_MUL, random_thread(), {4{32'h40400000}}, {4{32'hc0000000}},
					{4{32'hc0c00000}}, 1'b0, 2'd0);
				default: add_item(FP_ADD, random_thread(), {4{32'h3f800000}},
					{4{32'h30800000}}, {4{32'h3f800000}}, 1'b0, 2'd0);
			endcase
		end
		run_batch("streaming");
	endtask

	task automatic rollback_test();
		// Only the thread 2 item under an active rollback disappears
		add_item(FP_ADD, 2'd1, {4{32'h3fc00000}}, {4{32'h40100000}}, {4{32'h40700000}},
			1'b1, 2'd2);
		add_item(FP_SUB, 2'd2, {4{32'h40400000}}, {4{32'h40a00000}}, {4{32'hc0000000}},
			1'b1, 2'd2);
		add_item(FP_MUL, 2'd3, {4{32'h40400000}}, {4{32'hc0000000}}, {4{32'hc0c00000}},
			1'b1, 2'd2);
		add_item(FP_ADD, 2'd2, {4{32'h3f800000}}, {4{32'h30800000}}, {4{32'h3f800000}},
			1'b0, 2'd2);
		run_batch("rollback");
	endtask

	initial
	begin
		void'($urandom(32'h579e));
		reset = 1'b1;
		rollback_en = 1'b0;
		rollback_thread = 2'd0;
		in_valid = 1'b0;
		in_op = FP_ADD;
		in_thread = 2'd0;
		in_mask = 4'h0;
		in_operand1 = '0;
		in_operand2 = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		exact_add_sub_test();
		multiply_test();
		truncation_test();
		specials_test();
		streaming_test();
		rollback_test();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/fp_pipeline_asserts.sv
// Bound into fp_pipeline_top; assumes the fixed 4-cycle latency and level rollback squash
`timescale 1ns/10ps
`default_nettype none

module fp_pipeline_asserts
	import fp_pkg::*;
	(
	input wire clk,
	input wire reset,
	input wire rollback_en,
	input wire thread_idx_t rollback_thread,
	input wire in_valid,
	input wire thread_idx_t in_thread,
	input wire out_valid
	);

	logic accepted;

	// Item enters unless its thread is being rolled back
	assign accepted = in_valid && !(rollback_en && rollback_thread == in_thread);

	out_low_in_reset: assert property (@(posedge clk) $past(reset) |-> !out_valid)
		else $error("out_valid high while reset is held");

	valid_follows_input: assert property (@(posedge clk) disable iff (reset)
		$past(accepted, 4) |-> out_valid)
		else $error("accepted item gave no out_valid four cycles later");

	// Also covers any rise without a source item
	no_spurious_valid: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(accepted, 4))
		else $error("out_valid without an accepted item four cycles earlier");

endmodule

bind fp_pipeline_top fp_pipeline_asserts fp_pipeline_asserts_i
(
	.clk(clk),
	.reset(reset),
	.rollback_en(rollback_en),
	.rollback_thread(rollback_thread),
	.in_valid(in_valid),
	.in_thread(in_thread),
	.out_valid(out_valid)
);

`default_nettype wire

//--- design/fp_pipeline_top.sv
// Fixed 4-cycle latency, no back-pressure: every out_valid must be taken by the consumer
`timescale 1ns/10ps
`default_nettype none

module fp_pipeline_top
	import fp_pkg::*;
	#(
	parameter int LANES = fp_lanes
	)
	(
	input wire clk,
	input wire reset,
	input wire rollback_en,
	input wire thread_idx_t rollback_thread,
	input wire in_valid,
	input wire fp_op_t in_op,
	input wire thread_idx_t in_thread,
	input wire [LANES-1:0] in_mask,
	input wire float32_t [LANES-1:0] in_operand1,
	input wire float32_t [LANES-1:0] in_operand2,
	output logic out_valid,
	output thread_idx_t out_thread,
	output logic [LANES-1:0] out_mask,
	output float32_t [LANES-1:0] out_result
	);

	// Stage 1 to stage 2
	logic fx1_valid;
	fp_op_t fx1_op;
	thread_idx_t fx1_thread;
	logic [LANES-1:0] fx1_mask;
	logic [LANES-1:0][23:0] fx1_significand_le;
	logic [LANES-1:0][23:0] fx1_significand_se;
	logic [LANES-1:0][5:0] fx1_align_shift;
	logic [LANES-1:0][7:0] fx1_add_exponent;
	logic [LANES-1:0] fx1_logical_subtract;
	logic [LANES-1:0] fx1_add_sign;
	logic [LANES-1:0][9:0] fx1_mul_exponent;
	logic [LANES-1:0] fx1_mul_sign;
	logic [LANES-1:0] fx1_result_is_nan;
	logic [LANES-1:0] fx1_result_is_inf;

	// Stage 2 to stage 3
	logic fx2_valid;
	fp_op_t fx2_op;
	thread_idx_t fx2_thread;
	logic [LANES-1:0] fx2_mask;
	logic [LANES-1:0][26:0] fx2_significand_le;
	logic [LANES-1:0][26:0] fx2_significand_se_aligned;
	logic [LANES-1:0][7:0] fx2_add_exponent;
	logic [LANES-1:0] fx2_logical_subtract;
	logic [LANES-1:0] fx2_add_sign;
	logic [LANES-1:0][47:0] fx2_product;
	logic [LANES-1:0][9:0] fx2_mul_exponent;
	logic [LANES-1:0] fx2_mul_sign;
	logic [LANES-1:0] fx2_result_is_nan;
	logic [LANES-1:0] fx2_result_is_inf;

	// Stage 3 to stage 4
	logic fx3_valid;
	thread_idx_t fx3_thread;
	logic [LANES-1:0] fx3_mask;
	logic fx3_is_mul;
	logic [LANES-1:0][47:0] fx3_sum;
	logic [LANES-1:0][9:0] fx3_exponent;
	logic [LANES-1:0] fx3_sign;
	logic [LANES-1:0] fx3_result_is_nan;
	logic [LANES-1:0] fx3_result_is_inf;

	// Classify, order and squash
	fp_align_stage #(.LANES(LANES)) fp_align_stage_i (.*);

	// Align smaller significand, multiply
	fp_shift_mul_stage #(.LANES(LANES)) fp_shift_mul_stage_i (.*);

	// Add, subtract or select product
	fp_add_stage #(.LANES(LANES)) fp_add_stage_i (.*);

	// Normalize, truncate and pack
	fp_normalize_stage #(.LANES(LANES)) fp_normalize_stage_i (.*);

endmodule

`default_nettype wire

//--- design/fp_normalize_stage.sv
// Truncates toward zero; results below the normal range flush to signed zero, no flags
`timescale 1ns/10ps
`default_nettype none

module fp_normalize_stage
	import fp_pkg::*;
	#(
	parameter int LANES = fp_lanes
	)
	(
	input wire clk,
	input wire reset,
	input wire fx3_valid,
	input wire thread_idx_t fx3_thread,
	input wire [LANES-1:0] fx3_mask,
	input wire fx3_is_mul,
	input wire [LANES-1:0][47:0] fx3_sum,
	input wire [LANES-1:0][9:0] fx3_exponent,
	input wire [LANES-1:0] fx3_sign,
	input wire [LANES-1:0] fx3_result_is_nan,
	input wire [LANES-1:0] fx3_result_is_inf,
	output logic out_valid,
	output thread_idx_t out_thread,
	output logic [LANES-1:0] out_mask,
	output float32_t [LANES-1:0] out_result
	);

	// Leading zero count of a 48-bit magnitude
	function automatic logic [5:0] count_leading_zeros(input logic [47:0] value);
		logic [5:0] count;
		logic found;

		count = 6'd0;
		found = 1'b0;
		for (int i = 47; i >= 0; i--)
		begin
			if (!found)
			begin
				if (value[i])
					found = 1'b1;
				else
					count = count + 6'd1;
			end
		end
		return count;
	endfunction

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_gen
			logic [5:0] lz;
			logic [47:0] shifted;
			logic signed [10:0] norm_exp;
			logic [31:0] result;

			assign lz = count_leading_zeros(fx3_sum[lane]);

			// Leading one moves to bit 47, the 23 bits below it are the fraction
			assign shifted = fx3_sum[lane] << lz;

			// Both paths put the binary point under bit 46, so bit 47 means one up
			assign norm_exp = $signed({fx3_exponent[lane][9], fx3_exponent[lane]})
				+ 11'sd1 - $signed({5'b00000, lz});

			always_comb
			begin
				if (fx3_result_is_nan[lane])
					result = fp_qnan;
				else if (fx3_result_is_inf[lane])
					result = {fx3_sign[lane], 8'hff, 23'h0};
				else if (fx3_sum[lane] == '0)
				begin
					// Cancellation is +0, a zero product keeps its sign
					if (fx3_is_mul)
						result = {fx3_sign[lane], 31'h0};
					else
						result = 32'h0;
				end
				else if (norm_exp >= 11'sd255)
					result = {fx3_sign[lane], 8'hff, 23'h0};
				else if (norm_exp <= 11'sd0)
					result = {fx3_sign[lane], 31'h0};
				else
					result = {fx3_sign[lane], norm_exp[7:0], shifted[46:24]};
			end

			always_ff @(posedge clk)
			begin
				out_result[lane] <= result;
			end
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= fx3_valid;
	end

	always_ff @(posedge clk)
	begin
		out_thread <= fx3_thread;
		out_mask <= fx3_mask;
	end

endmodule

`default_nettype wire

//--- design/fp_add_stage.sv
// Sum is a non-negative magnitude since stage 1 orders operands; no normalization here
`timescale 1ns/10ps
`default_nettype none

module fp_add_stage
	import fp_pkg::*;
	#(
	parameter int LANES = fp_lanes
	)
	(
	input wire clk,
	input wire reset,
	input wire fx2_valid,
	input wire fp_op_t fx2_op,
	input wire thread_idx_t fx2_thread,
	input wire [LANES-1:0] fx2_mask,
	input wire [LANES-1:0][26:0] fx2_significand_le,
	input wire [LANES-1:0][26:0] fx2_significand_se_aligned,
	input wire [LANES-1:0][7:0] fx2_add_exponent,
	input wire [LANES-1:0] fx2_logical_subtract,
	input wire [LANES-1:0] fx2_add_sign,
	input wire [LANES-1:0][47:0] fx2_product,
	input wire [LANES-1:0][9:0] fx2_mul_exponent,
	input wire [LANES-1:0] fx2_mul_sign,
	input wire [LANES-1:0] fx2_result_is_nan,
	input wire [LANES-1:0] fx2_result_is_inf,
	output logic fx3_valid,
	output thread_idx_t fx3_thread,
	output logic [LANES-1:0] fx3_mask,
	output logic fx3_is_mul,
	output logic [LANES-1:0][47:0] fx3_sum,
	output logic [LANES-1:0][9:0] fx3_exponent,
	output logic [LANES-1:0] fx3_sign,
	output logic [LANES-1:0] fx3_result_is_nan,
	output logic [LANES-1:0] fx3_result_is_inf
	);

	logic is_mul;

	assign is_mul = fx2_op == FP_MUL;

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_gen
			logic [27:0] add_result;

			// Extra top bit holds the carry of a true add
			assign add_result = fx2_logical_subtract[lane]
				? {1'b0, fx2_significand_le[lane]} - {1'b0, fx2_significand_se_aligned[lane]}
				: {1'b0, fx2_significand_le[lane]} + {1'b0, fx2_significand_se_aligned[lane]};

			always_ff @(posedge clk)
			begin
				if (is_mul)
				begin
					fx3_sum[lane] <= fx2_product[lane];
					fx3_exponent[lane] <= fx2_mul_exponent[lane];
					fx3_sign[lane] <= fx2_mul_sign[lane];
				end
				else
				begin
					// Hidden bit lines up with bit 46, same as the product
					fx3_sum[lane] <= {add_result, 20'h0};
					fx3_exponent[lane] <= {2'b00, fx2_add_exponent[lane]};
					fx3_sign[lane] <= fx2_add_sign[lane];
				end
			end
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			fx3_valid <= 1'b0;
		else
			fx3_valid <= fx2_valid;
	end

	always_ff @(posedge clk)
	begin
		fx3_thread <= fx2_thread;
		fx3_mask <= fx2_mask;
		fx3_is_mul <= is_mul;
		fx3_result_is_nan <= fx2_result_is_nan;
		fx3_result_is_inf <= fx2_result_is_inf;
	end

endmodule

`default_nettype wire

//--- design/fp_shift_mul_stage.sv
// Alignment shift is at most 27; product is the full 48-bit unsigned significand product
`timescale 1ns/10ps
`default_nettype none

module fp_shift_mul_stage
	import fp_pkg::*;
	#(
	parameter int LANES = fp_lanes
	)
	(
	input wire clk,
	input wire reset,
	input wire fx1_valid,
	input wire fp_op_t fx1_op,
	input wire thread_idx_t fx1_thread,
	input wire [LANES-1:0] fx1_mask,
	input wire [LANES-1:0][23:0] fx1_significand_le,
	input wire [LANES-1:0][23:0] fx1_significand_se,
	input wire [LANES-1:0][5:0] fx1_align_shift,
	input wire [LANES-1:0][7:0] fx1_add_exponent,
	input wire [LANES-1:0] fx1_logical_subtract,
	input wire [LANES-1:0] fx1_add_sign,
	input wire [LANES-1:0][9:0] fx1_mul_exponent,
	input wire [LANES-1:0] fx1_mul_sign,
	input wire [LANES-1:0] fx1_result_is_nan,
	input wire [LANES-1:0] fx1_result_is_inf,
	output logic fx2_valid,
	output fp_op_t fx2_op,
	output thread_idx_t fx2_thread,
	output logic [LANES-1:0] fx2_mask,
	output logic [LANES-1:0][26:0] fx2_significand_le,
	output logic [LANES-1:0][26:0] fx2_significand_se_aligned,
	output logic [LANES-1:0][7:0] fx2_add_exponent,
	output logic [LANES-1:0] fx2_logical_subtract,
	output logic [LANES-1:0] fx2_add_sign,
	output logic [LANES-1:0][47:0] fx2_product,
	output logic [LANES-1:0][9:0] fx2_mul_exponent,
	output logic [LANES-1:0] fx2_mul_sign,
	output logic [LANES-1:0] fx2_result_is_nan,
	output logic [LANES-1:0] fx2_result_is_inf
	);

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_gen
			logic [53:0] shift_ext;
			logic sticky;

			// Upper half keeps the aligned value, lower half catches shifted-out bits
			assign shift_ext = {fx1_significand_se[lane], 3'b000, 27'h0}
				>> fx1_align_shift[lane];
			assign sticky = |shift_ext[26:0];

			always_ff @(posedge clk)
			begin
				// Guard, round and sticky of the larger operand are zero
				fx2_significand_le[lane] <= {fx1_significand_le[lane], 3'b000};
				fx2_significand_se_aligned[lane] <= {shift_ext[53:28], shift_ext[27] | sticky};

				// Swap does not matter for multiply
				fx2_product[lane] <= fx1_significand_le[lane] * fx1_significand_se[lane];
			end
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			fx2_valid <= 1'b0;
		else
			fx2_valid <= fx1_valid;
	end

	// Sideband and per-lane fields move along unchanged
	always_ff @(posedge clk)
	begin
		fx2_op <= fx1_op;
		fx2_thread <= fx1_thread;
		fx2_mask <= fx1_mask;
		fx2_add_exponent <= fx1_add_exponent;
		fx2_logical_subtract <= fx1_logical_subtract;
		fx2_add_sign <= fx1_add_sign;
		fx2_mul_exponent <= fx1_mul_exponent;
		fx2_mul_sign <= fx1_mul_sign;
		fx2_result_is_nan <= fx1_result_is_nan;
		fx2_result_is_inf <= fx1_result_is_inf;
	end

endmodule

`default_nettype wire

//--- design/fp_align_stage.sv
// Zero exponent operands count as zero; operand 1 keeps the larger slot on equal magnitudes
`timescale 1ns/10ps
`default_nettype none

module fp_align_stage
	import fp_pkg::*;
	#(
	parameter int LANES = fp_lanes
	)
	(
	input wire clk,
	input wire reset,
	input wire rollback_en,
	input wire thread_idx_t rollback_thread,
	input wire in_valid,
	input wire fp_op_t in_op,
	input wire thread_idx_t in_thread,
	input wire [LANES-1:0] in_mask,
	input wire float32_t [LANES-1:0] in_operand1,
	input wire float32_t [LANES-1:0] in_operand2,
	output logic fx1_valid,
	output fp_op_t fx1_op,
	output thread_idx_t fx1_thread,
	output logic [LANES-1:0] fx1_mask,
	output logic [LANES-1:0][23:0] fx1_significand_le,
	output logic [LANES-1:0][23:0] fx1_significand_se,
	output logic [LANES-1:0][5:0] fx1_align_shift,
	output logic [LANES-1:0][7:0] fx1_add_exponent,
	output logic [LANES-1:0] fx1_logical_subtract,
	output logic [LANES-1:0] fx1_add_sign,
	output logic [LANES-1:0][9:0] fx1_mul_exponent,
	output logic [LANES-1:0] fx1_mul_sign,
	output logic [LANES-1:0] fx1_result_is_nan,
	output logic [LANES-1:0] fx1_result_is_inf
	);

	logic is_sub;
	logic is_mul;

	assign is_sub = in_op == FP_SUB;
	assign is_mul = in_op == FP_MUL;

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_gen
			float32_t op1;
			float32_t op2;
			logic [23:0] full_sig1;
			logic [23:0] full_sig2;
			logic op1_zero;
			logic op2_zero;
			logic op1_inf;
			logic op2_inf;
			logic op1_nan;
			logic op2_nan;
			logic op1_larger;
			logic [7:0] exp_diff;
			logic logical_sub;
			logic result_nan;

			assign op1 = in_operand1[lane];
			assign op2 = in_operand2[lane];

			// Flush to zero, no hidden bit and no fraction
			assign op1_zero = op1.exponent == 8'h00;
			assign op2_zero = op2.exponent == 8'h00;
			assign full_sig1 = op1_zero ? 24'h0 : {1'b1, op1.significand};
			assign full_sig2 = op2_zero ? 24'h0 : {1'b1, op2.significand};

			assign op1_inf = op1.exponent == 8'hff && op1.significand == '0;
			assign op2_inf = op2.exponent == 8'hff && op2.significand == '0;
			assign op1_nan = op1.exponent == 8'hff && op1.significand != '0;
			assign op2_nan = op2.exponent == 8'hff && op2.significand != '0;

			// Magnitude compare, exponent first then significand
			assign op1_larger = op1.exponent > op2.exponent
				|| (op1.exponent == op2.exponent && full_sig1 >= full_sig2);
			assign exp_diff = op1_larger ? op1.exponent - op2.exponent
				: op2.exponent - op1.exponent;

			// Effective operation on magnitudes
			assign logical_sub = op1.sign ^ op2.sign ^ is_sub;

			always_comb
			begin
				if (is_mul)
					result_nan = op1_nan || op2_nan || (op1_inf && op2_zero)
						|| (op2_inf && op1_zero);
				else
					result_nan = op1_nan || op2_nan || (op1_inf && op2_inf && logical_sub);
			end

			always_ff @(posedge clk)
			begin
				if (op1_larger)
				begin
					fx1_significand_le[lane] <= full_sig1;
					fx1_significand_se[lane] <= full_sig2;
					fx1_add_exponent[lane] <= op1.exponent;
					fx1_add_sign[lane] <= op1.sign;
				end
				else
				begin
					// Operand 2 dominates, its sign flips for a subtract
					fx1_significand_le[lane] <= full_sig2;
					fx1_significand_se[lane] <= full_sig1;
					fx1_add_exponent[lane] <= op2.exponent;
					fx1_add_sign[lane] <= op2.sign ^ is_sub;
				end

				// Beyond the limit everything lands in sticky
				if (exp_diff < {2'b00, fp_max_align})
					fx1_align_shift[lane] <= exp_diff[5:0];
				else
					fx1_align_shift[lane] <= fp_max_align;

				fx1_logical_subtract[lane] <= logical_sub;

				// Biased sum, may go negative or past 255
				fx1_mul_exponent[lane] <= {2'b00, op1.exponent} + {2'b00, op2.exponent}
					- {2'b00, fp_exp_bias};
				fx1_mul_sign[lane] <= op1.sign ^ op2.sign;

				fx1_result_is_nan[lane] <= result_nan;
				fx1_result_is_inf[lane] <= !result_nan && (op1_inf || op2_inf);
			end
		end
	endgenerate

	// Rollback drops the item of the matching thread on entry
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			fx1_valid <= 1'b0;
		else
			fx1_valid <= in_valid && !(rollback_en && rollback_thread == in_thread);
	end

	always_ff @(posedge clk)
	begin
		fx1_op <= in_op;
		fx1_thread <= in_thread;
		fx1_mask <= in_mask;
	end

endmodule

`default_nettype wire

//--- design/fp_pkg.sv
// Binary32 only: subnormals flushed to zero, truncating rounding, no exception flags
`default_nettype none

package fp_pkg;

	// Default lane count
	// Top level overrides this through its LANES parameter
	localparam int fp_lanes = 4;

	// Hardware thread index, four threads
	typedef logic [1:0] thread_idx_t;

	// Operations handled by the multi-cycle pipeline
	typedef enum logic [1:0]
	{
		FP_ADD = 2'd0,
		FP_SUB = 2'd1,
		FP_MUL = 2'd2
	} fp_op_t;

	// IEEE 754 binary32 layout
	typedef struct packed
	{
		logic sign;
		logic [7:0] exponent;
		logic [22:0] significand;
	} float32_t;

	// Canonical quiet NaN
	// Every invalid operation collapses to this pattern
	localparam logic [31:0] fp_qnan = 32'h7fc00000;

	// Exponent bias
	localparam logic [7:0] fp_exp_bias = 8'd127;

	// Alignment shift limit
	// 24 significand bits plus guard, round and sticky
	localparam logic [5:0] fp_max_align = 6'd27;

endpackage

`default_nettype wire
